// ==== hw/msx_cart_pkg.sv ====
// shared constants of the msx cartridge
// bus widths, memory window, bank sizes and i/o port numbers
`default_nettype none

package msx_cart_pkg;

	// ----------------------------------------
	// bus widths
	// ----------------------------------------
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// ----------------------------------------
	// memory window and banking
	// ----------------------------------------
	// ram is visible in page 1 of the slot only
	localparam logic [ADDR_W-1:0] MEM_WIN_BASE = 16'h4000;
	localparam logic [ADDR_W-1:0] MEM_WIN_TOP = 16'h7FFF;
	// 8 KB per page, two pages in the window
	localparam int PAGE_W = 13;
	localparam int BANK_W = 2;
	// 4 banks of 8 KB, 32 KB in total
	localparam int RAM_BANKS = 4;

	// ----------------------------------------
	// i/o ports, decoded from the low address byte
	// ----------------------------------------
	localparam logic [7:0] IO_BANK0_PORT = 8'hF0;
	localparam logic [7:0] IO_BANK1_PORT = 8'hF1;
	localparam logic [7:0] IO_SCRATCH_PORT = 8'hF2;
	// bank registers start as an identity mapping of the window
	localparam logic [BANK_W-1:0] BANK0_RESET = 2'd0;
	localparam logic [BANK_W-1:0] BANK1_RESET = 2'd1;

endpackage

`default_nettype wire

// ==== hw/msx_slot_bridge.sv ====
// msx slot bridge
// turns the asynchronous cartridge strobes into request levels on clk,
// latches address and write data, returns read data to the slot
`timescale 1ns/100ps
`default_nettype none

module msx_slot_bridge import msx_cart_pkg::*; (
	input wire clk,
	input wire n_reset,
	// cartridge slot side
	input wire [ADDR_W-1:0] adr,
	input wire [DATA_W-1:0] i_data,
	output logic [DATA_W-1:0] o_data,
	output logic is_output,
	input wire n_sltsl,
	input wire n_rd,
	input wire n_wr,
	input wire n_ioreq,
	// internal bus side
	output logic [ADDR_W-1:0] bus_address,
	output logic [DATA_W-1:0] bus_write_data,
	output logic bus_write,
	output logic bus_memory_req,
	output logic bus_io_req,
	input wire [DATA_W-1:0] bus_read_data,
	input wire bus_read_data_en,
	input wire bus_ack
);

	// strobes sampled into the clk domain
	logic n_sltsl_q;
	logic n_rd_q;
	logic n_wr_q;
	logic n_ioreq_q;
	// falling edges of the select strobes
	logic memory_start;
	logic io_start;
	// returned read data is held while n_rd stays low
	logic read_valid_q;

	// ----------------------------------------
	// strobe sampling
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			n_sltsl_q <= 1'b1;
			n_rd_q <= 1'b1;
			n_wr_q <= 1'b1;
			n_ioreq_q <= 1'b1;
		end else begin
			n_sltsl_q <= n_sltsl;
			n_rd_q <= n_rd;
			n_wr_q <= n_wr;
			n_ioreq_q <= n_ioreq;
		end
	end

	// edge seen on the first clk that samples the strobe low
	assign memory_start = n_sltsl_q & ~n_sltsl;
	assign io_start = n_ioreq_q & ~n_ioreq;

	// ----------------------------------------
	// request levels
	// ----------------------------------------
	// ack wins, a second edge while pending merges into the request
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			bus_memory_req <= 1'b0;
			bus_io_req <= 1'b0;
		end else if (bus_ack) begin
			bus_memory_req <= 1'b0;
			bus_io_req <= 1'b0;
		end else begin
			if (memory_start) begin
				bus_memory_req <= 1'b1;
			end
			if (io_start) begin
				bus_io_req <= 1'b1;
			end
		end
	end

	// ----------------------------------------
	// address and write data latch
	// ----------------------------------------
	// address follows adr while either data strobe is low
	always_ff @(posedge clk) begin
		if (!n_wr_q || !n_rd_q) begin
			bus_address <= adr;
		end
	end

	always_ff @(posedge clk) begin
		if (!n_wr_q) begin
			bus_write_data <= i_data;
		end
	end

	assign bus_write = ~n_wr_q;

	// ----------------------------------------
	// slot response
	// ----------------------------------------
	// cleared once n_rd is back high, so the next read starts clean
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			o_data <= '0;
			read_valid_q <= 1'b0;
		end else if (n_rd_q) begin
			o_data <= '0;
			read_valid_q <= 1'b0;
		end else if (bus_read_data_en) begin
			o_data <= bus_read_data;
			read_valid_q <= 1'b1;
		end
	end

	// drop the bus driver as soon as the host releases n_rd
	assign is_output = read_valid_q & ~n_rd;

endmodule

`default_nettype wire

// ==== hw/cart_bus_decode.sv ====
// internal bus decoder
// picks the ram or the i/o block for each request and merges the answers
`timescale 1ns/100ps
`default_nettype none

module cart_bus_decode import msx_cart_pkg::*; (
	input wire clk,
	input wire n_reset,
	// from the bridge
	input wire [ADDR_W-1:0] bus_address,
	input wire [DATA_W-1:0] bus_write_data,
	input wire bus_write,
	input wire bus_memory_req,
	input wire bus_io_req,
	output logic [DATA_W-1:0] bus_read_data,
	output logic bus_read_data_en,
	output logic bus_ack,
	// to the targets
	output logic [ADDR_W-1:0] tgt_address,
	output logic [DATA_W-1:0] tgt_write_data,
	output logic tgt_write,
	output logic ram_sel,
	output logic io_sel,
	input wire ram_done,
	input wire [DATA_W-1:0] ram_read_data,
	input wire io_done,
	input wire [DATA_W-1:0] io_read_data,
	input wire io_hit
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT_ADR,
		ST_ISSUE,
		ST_ANSWER
	} state_t;

	state_t state_q;
	logic in_window;
	logic mem_go;
	logic io_go;
	// no target was strobed for this access
	logic unmapped_q;

	assign in_window = (bus_address >= MEM_WIN_BASE) && (bus_address <= MEM_WIN_TOP);
	assign mem_go = bus_memory_req & in_window;
	// i/o registers judge the port themselves
	assign io_go = ~bus_memory_req & bus_io_req;

	// ----------------------------------------
	// request sequencing
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			state_q <= ST_IDLE;
			ram_sel <= 1'b0;
			io_sel <= 1'b0;
			unmapped_q <= 1'b0;
		end else begin
			ram_sel <= 1'b0;
			io_sel <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (bus_memory_req || bus_io_req) begin
						state_q <= ST_WAIT_ADR;
					end
				end
				// address was latched by the bridge one edge ago
				ST_WAIT_ADR: begin
					ram_sel <= mem_go;
					io_sel <= io_go;
					unmapped_q <= ~mem_go & ~io_go;
					state_q <= ST_ISSUE;
				end
				ST_ISSUE: state_q <= ST_ANSWER;
				// ack goes out here, request drops on the next edge
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// shared target fields, loaded together with the select
	always_ff @(posedge clk) begin
		if (state_q == ST_WAIT_ADR) begin
			tgt_address <= bus_address;
			tgt_write_data <= bus_write_data;
			tgt_write <= bus_write;
		end
	end

	// ----------------------------------------
	// answer merge
	// ----------------------------------------
	// unmapped access answers in the cycle a target would have
	assign bus_ack = ram_done | io_done | ((state_q == ST_ANSWER) & unmapped_q);
	assign bus_read_data = ram_done ? ram_read_data : io_read_data;
	assign bus_read_data_en = ~tgt_write & (ram_done | (io_done & io_hit));

endmodule

`default_nettype wire

// ==== hw/cart_banked_ram.sv ====
// bank-mapped cartridge ram
// two 8 KB pages in the window, each backed by a selectable 8 KB bank
`timescale 1ns/100ps
`default_nettype none

module cart_banked_ram import msx_cart_pkg::*; (
	input wire clk,
	input wire n_reset,
	// strobe from the decoder
	input wire [ADDR_W-1:0] tgt_address,
	input wire [DATA_W-1:0] tgt_write_data,
	input wire tgt_write,
	input wire ram_sel,
	// bank numbers from the i/o block
	input wire [BANK_W-1:0] bank0,
	input wire [BANK_W-1:0] bank1,
	// answer
	output logic ram_done,
	output logic [DATA_W-1:0] ram_read_data
);

	// 32 KB storage, indexed by {bank, page offset}
	logic [DATA_W-1:0] mem [RAM_BANKS * (2 ** PAGE_W)];

	// address relative to the start of the window
	logic [ADDR_W-1:0] win_offset;
	// page 0 or page 1 of the window
	logic page;
	logic [BANK_W-1:0] bank;
	logic [BANK_W+PAGE_W-1:0] index;

	// ----------------------------------------
	// bank mapping
	// ----------------------------------------
	assign win_offset = tgt_address - MEM_WIN_BASE;
	assign page = win_offset[PAGE_W];

	// 0x4000..0x5FFF uses bank0, 0x6000..0x7FFF uses bank1
	assign bank = page ? bank1 : bank0;
	assign index = {bank, win_offset[PAGE_W-1:0]};

	// ----------------------------------------
	// storage access
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (ram_sel) begin
			if (tgt_write) begin
				mem[index] <= tgt_write_data;
			end else begin
				ram_read_data <= mem[index];
			end
		end
	end

	// ----------------------------------------
	// done pulse
	// ----------------------------------------
	// one cycle after every strobe, reads and writes alike
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ram_done <= 1'b0;
		end else begin
			ram_done <= ram_sel;
		end
	end

endmodule

`default_nettype wire

// ==== hw/cart_io_regs.sv ====
// cartridge i/o registers
// two bank numbers and one scratch byte on ports 0xF0..0xF2
`timescale 1ns/100ps
`default_nettype none

module cart_io_regs import msx_cart_pkg::*; (
	input wire clk,
	input wire n_reset,
	input wire [ADDR_W-1:0] tgt_address,
	input wire [DATA_W-1:0] tgt_write_data,
	input wire tgt_write,
	input wire io_sel,
	output logic io_done,
	output logic [DATA_W-1:0] io_read_data,
	output logic io_hit,
	output logic [BANK_W-1:0] bank0,
	output logic [BANK_W-1:0] bank1
);

	// port number is the low address byte only
	logic [7:0] port;
	logic hit_bank0;
	logic hit_bank1;
	logic hit_scratch;
	logic [DATA_W-1:0] scratch_q;

	assign port = tgt_address[7:0];
	assign hit_bank0 = (port == IO_BANK0_PORT);
	assign hit_bank1 = (port == IO_BANK1_PORT);
	assign hit_scratch = (port == IO_SCRATCH_PORT);

	// ----------------------------------------
	// control and bank registers
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			bank0 <= BANK0_RESET;
			bank1 <= BANK1_RESET;
			io_done <= 1'b0;
			io_hit <= 1'b0;
		end else begin
			io_done <= io_sel;
			io_hit <= io_sel & (hit_bank0 | hit_bank1 | hit_scratch);
			// bank writes keep only the low BANK_W bits
			if (io_sel && tgt_write && hit_bank0) begin
				bank0 <= tgt_write_data[BANK_W-1:0];
			end
			if (io_sel && tgt_write && hit_bank1) begin
				bank1 <= tgt_write_data[BANK_W-1:0];
			end
		end
	end

	// scratch byte and read path
	always_ff @(posedge clk) begin
		if (io_sel && tgt_write && hit_scratch) begin
			scratch_q <= tgt_write_data;
		end
		if (io_sel && !tgt_write) begin
			if (hit_bank0) io_read_data <= {{(DATA_W-BANK_W){1'b0}}, bank0};
			else if (hit_bank1) io_read_data <= {{(DATA_W-BANK_W){1'b0}}, bank1};
			else if (hit_scratch) io_read_data <= scratch_q;
			else io_read_data <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== hw/msx_cartridge.sv ====
// msx cartridge top level
// slot bridge, bus decoder, banked ram and i/o registers
`timescale 1ns/100ps
`default_nettype none

module msx_cartridge import msx_cart_pkg::*; (
	input wire clk,
	input wire n_reset,
	input wire [ADDR_W-1:0] adr,
	input wire [DATA_W-1:0] i_data,
	output logic [DATA_W-1:0] o_data,
	output logic is_output,
	input wire n_sltsl,
	input wire n_rd,
	input wire n_wr,
	input wire n_ioreq
);

	// ----------------------------------------
	// internal bus, bridge to decoder
	// ----------------------------------------
	logic [ADDR_W-1:0] bus_address;
	logic [DATA_W-1:0] bus_write_data;
	logic [DATA_W-1:0] bus_read_data;
	logic bus_write, bus_memory_req, bus_io_req;
	logic bus_read_data_en, bus_ack;

	// decoder to targets
	logic [ADDR_W-1:0] tgt_address;
	logic [DATA_W-1:0] tgt_write_data;
	logic [DATA_W-1:0] ram_read_data, io_read_data;
	logic tgt_write, ram_sel, io_sel;
	logic ram_done, io_done, io_hit;
	logic [BANK_W-1:0] bank0, bank1;

	msx_slot_bridge msx_slot_bridge_i (
		.clk, .n_reset, .adr, .i_data, .o_data, .is_output,
		.n_sltsl, .n_rd, .n_wr, .n_ioreq,
		.bus_address, .bus_write_data, .bus_write, .bus_memory_req, .bus_io_req,
		.bus_read_data, .bus_read_data_en, .bus_ack
	);

	cart_bus_decode cart_bus_decode_i (
		.clk, .n_reset,
		.bus_address, .bus_write_data, .bus_write, .bus_memory_req, .bus_io_req,
		.bus_read_data, .bus_read_data_en, .bus_ack,
		.tgt_address, .tgt_write_data, .tgt_write, .ram_sel, .io_sel,
		.ram_done, .ram_read_data, .io_done, .io_read_data, .io_hit
	);

	// ram page mapping follows the i/o bank registers
	cart_banked_ram cart_banked_ram_i (
		.clk, .n_reset, .tgt_address, .tgt_write_data, .tgt_write, .ram_sel,
		.bank0, .bank1, .ram_done, .ram_read_data
	);

	cart_io_regs cart_io_regs_i (
		.clk, .n_reset, .tgt_address, .tgt_write_data, .tgt_write, .io_sel,
		.io_done, .io_read_data, .io_hit, .bank0, .bank1
	);

endmodule

`default_nettype wire

// ==== testbench/msx_cart_bus_assert.sv ====
// internal bus protocol checks
// bound to the bus decoder
`timescale 1ns/100ps
`default_nettype none

module msx_cart_bus_assert (
	input wire clk,
	input wire n_reset,
	input wire bus_write,
	input wire bus_memory_req,
	input wire bus_io_req,
	input wire bus_ack,
	input wire bus_read_data_en,
	input wire ram_sel,
	input wire io_sel
);

	// ack is a single cycle pulse
	ack_one_cycle: assert property (@(posedge clk) disable iff (!n_reset)
		bus_ack |=> !bus_ack)
		else $error("bus_ack held for more than one cycle");

	// an ack only answers a pending request, which is gone on the next edge
	ack_with_request: assert property (@(posedge clk) disable iff (!n_reset)
		bus_ack |-> (bus_memory_req || bus_io_req))
		else $error("bus_ack without a pending request");

	request_drops: assert property (@(posedge clk) disable iff (!n_reset)
		bus_ack |=> !(bus_memory_req || bus_io_req))
		else $error("request still pending after bus_ack");

	// one target per access, each select only for its own kind of request
	one_target: assert property (@(posedge clk) disable iff (!n_reset)
		(ram_sel || io_sel) |-> !(ram_sel && io_sel)
			&& (ram_sel ? bus_memory_req : bus_io_req))
		else $error("target select high together or without a matching request");

	// read data only on the ack of a read
	read_en_with_ack: assert property (@(posedge clk) disable iff (!n_reset)
		bus_read_data_en |-> bus_ack && !bus_write)
		else $error("bus_read_data_en without bus_ack or during a write");

endmodule

bind cart_bus_decode msx_cart_bus_assert msx_cart_bus_assert_i (
	.clk, .n_reset, .bus_write, .bus_memory_req, .bus_io_req, .bus_ack,
	.bus_read_data_en, .ram_sel, .io_sel
);

`default_nettype wire

// ==== testbench/tb_msx_cartridge.sv ====
// testbench for the msx cartridge
// host slot driver, reference model with expected_read, compare process, timeout
`timescale 1ns/100ps
`default_nettype none

module tb_msx_cartridge import msx_cart_pkg::*; ();

	localparam int LOW_CYCLES = 8;
	localparam int HIGH_CYCLES = 4;
	localparam int RANDOM_ACCESSES = 300;
	localparam int FILL_OFFSETS = 16;
	// the whole sequence needs roughly 5000 cycles
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int unsigned SEED = 37064;
	// msb is the expected is_output level, low byte the expected o_data
	localparam logic [DATA_W:0] NO_DRIVE = '0;

	logic clk;
	logic n_reset;
	logic [ADDR_W-1:0] adr;
	logic [DATA_W-1:0] i_data;
	logic [DATA_W-1:0] o_data;
	logic is_output;
	logic n_sltsl;
	logic n_rd;
	logic n_wr;
	logic n_ioreq;

	// reference model state
	logic [DATA_W-1:0] ref_mem [RAM_BANKS * (2 ** PAGE_W)];
	logic [BANK_W-1:0] ref_bank0;
	logic [BANK_W-1:0] ref_bank1;
	logic [DATA_W-1:0] ref_scratch;

	// reads waiting for the compare process
	logic [DATA_W:0] expected_q[$];
	logic [DATA_W:0] observed_q[$];
	logic [ADDR_W-1:0] address_q[$];
	event sample_ready;
	int cycle_count;

	msx_cartridge msx_cartridge_i (
		.clk, .n_reset, .adr, .i_data, .o_data, .is_output,
		.n_sltsl, .n_rd, .n_wr, .n_ioreq
	);

	always #2 clk = ~clk;

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic logic in_window(input logic [ADDR_W-1:0] address);
		return (address >= MEM_WIN_BASE) && (address <= MEM_WIN_TOP);
	endfunction

	// lower 8 KB page follows bank0, upper page follows bank1
	function automatic int ram_index(input logic [ADDR_W-1:0] address);
		logic [ADDR_W-1:0] offset;
		logic [BANK_W-1:0] bank;
		offset = address - MEM_WIN_BASE;
		bank = offset[PAGE_W] ? ref_bank1 : ref_bank0;
		return int'(bank) * (2 ** PAGE_W) + int'(offset[PAGE_W-1:0]);
	endfunction

	function automatic logic [DATA_W:0] expected_read(input logic is_io,
			input logic [ADDR_W-1:0] address);
		logic [DATA_W:0] result;
		result = NO_DRIVE;
		if (!is_io) begin
			if (in_window(address)) result = {1'b1, ref_mem[ram_index(address)]};
		end else begin
			case (address[7:0])
				IO_BANK0_PORT: result = {1'b1, {(DATA_W-BANK_W){1'b0}}, ref_bank0};
				IO_BANK1_PORT: result = {1'b1, {(DATA_W-BANK_W){1'b0}}, ref_bank1};
				IO_SCRATCH_PORT: result = {1'b1, ref_scratch};
				default: result = NO_DRIVE;
			endcase
		end
		return result;
	endfunction

	function automatic void model_write(input logic is_io, input logic [ADDR_W-1:0] address,
			input logic [DATA_W-1:0] data);
		if (!is_io) begin
			if (in_window(address)) ref_mem[ram_index(address)] = data;
		end else begin
			case (address[7:0])
				IO_BANK0_PORT: ref_bank0 = data[BANK_W-1:0];
				IO_BANK1_PORT: ref_bank1 = data[BANK_W-1:0];
				IO_SCRATCH_PORT: ref_scratch = data;
				default: ;
			endcase
		end
	endfunction

	// ----------------------------------------
	// host slot driver
	// ----------------------------------------
	// strobes low for LOW_CYCLES edges, response sampled in the last low cycle
	task automatic host_access(input logic is_io, input logic is_write,
			input logic [ADDR_W-1:0] address, input logic [DATA_W-1:0] data,
			output logic [DATA_W:0] observed);
		@(posedge clk);
		#1;
		adr = address;
		i_data = data;
		n_sltsl = is_io;
		n_ioreq = !is_io;
		n_wr = !is_write;
		n_rd = is_write;
		repeat (LOW_CYCLES - 1) @(posedge clk);
		@(negedge clk);
		observed = {is_output, o_data};
		@(posedge clk);
		#1;
		n_sltsl = 1'b1;
		n_ioreq = 1'b1;
		n_wr = 1'b1;
		n_rd = 1'b1;
		repeat (HIGH_CYCLES - 1) @(posedge clk);
	endtask

	task automatic record_check(input logic [ADDR_W-1:0] address,
			input logic [DATA_W:0] expected, input logic [DATA_W:0] observed);
		expected_q.push_back(expected);
		observed_q.push_back(observed);
		address_q.push_back(address);
		-> sample_ready;
	endtask

	task automatic mem_read(input logic [ADDR_W-1:0] address);
		logic [DATA_W:0] expected;
		logic [DATA_W:0] observed;
		expected = expected_read(1'b0, address);
		host_access(1'b0, 1'b0, address, '0, observed);
		record_check(address, expected, observed);
	endtask

	task automatic mem_write(input logic [ADDR_W-1:0] address, input logic [DATA_W-1:0] data);
		logic [DATA_W:0] observed;
		host_access(1'b0, 1'b1, address, data, observed);
		model_write(1'b0, address, data);
	endtask

	// upper address byte is random, only the low byte selects the port
	task automatic io_read(input logic [7:0] port);
		logic [7:0] high;
		logic [DATA_W:0] expected;
		logic [DATA_W:0] observed;
		high = $urandom;
		expected = expected_read(1'b1, {high, port});
		host_access(1'b1, 1'b0, {high, port}, '0, observed);
		record_check({high, port}, expected, observed);
	endtask

	task automatic io_write(input logic [7:0] port, input logic [DATA_W-1:0] data);
		logic [7:0] high;
		logic [DATA_W:0] observed;
		high = $urandom;
		host_access(1'b1, 1'b1, {high, port}, data, observed);
		model_write(1'b1, {high, port}, data);
	endtask

	// bus idle, nothing may be driven towards the slot
	task automatic check_idle();
		@(negedge clk);
		record_check('0, NO_DRIVE, {is_output, o_data});
	endtask

	// ----------------------------------------
	// random traffic
	// ----------------------------------------
	// every bank gets the low FILL_OFFSETS bytes, so random reads never hit unwritten ram
	task automatic fill_banks();
		logic [DATA_W-1:0] data;
		for (int bank = 0; bank < RAM_BANKS; bank++) begin
			io_write(IO_BANK0_PORT, DATA_W'(bank));
			for (int offset = 0; offset < FILL_OFFSETS; offset++) begin
				data = $urandom;
				mem_write(MEM_WIN_BASE + ADDR_W'(offset), data);
			end
		end
	endtask

	function automatic logic [ADDR_W-1:0] random_mem_address();
		logic [ADDR_W-1:0] address;
		address = $urandom;
		if ($urandom % 4 == 0) begin
			// fold window hits to 0xC000..0xFFFF
			if (in_window(address)) address = address ^ 16'h8000;
		end else begin
			address = MEM_WIN_BASE + ADDR_W'(($urandom % 2) << PAGE_W)
				+ ADDR_W'($urandom % FILL_OFFSETS);
		end
		return address;
	endfunction

	function automatic logic [7:0] random_port();
		logic [7:0] port;
		port = $urandom;
		case ($urandom % 4)
			0: port = IO_BANK0_PORT;
			1: port = IO_BANK1_PORT;
			2: port = IO_SCRATCH_PORT;
			default: ;
		endcase
		return port;
	endfunction

	task automatic random_accesses();
		int unsigned kind;
		logic [DATA_W-1:0] data;
		for (int i = 0; i < RANDOM_ACCESSES; i++) begin
			kind = $urandom % 4;
			data = $urandom;
			case (kind)
				0: mem_read(random_mem_address());
				1: mem_write(random_mem_address(), data);
				2: io_read(random_port());
				default: io_write(random_port(), data);
			endcase
		end
	endtask

	// ----------------------------------------
	// compare process and timeout
	// ----------------------------------------
	initial begin : compare
		logic [DATA_W:0] exp_word;
		logic [DATA_W:0] obs_word;
		logic [ADDR_W-1:0] chk_address;
		forever begin
			@(sample_ready);
			while (observed_q.size() != 0) begin
				exp_word = expected_q.pop_front();
				obs_word = observed_q.pop_front();
				chk_address = address_q.pop_front();
				assert (obs_word[DATA_W] == exp_word[DATA_W]) else begin
					$display("MISMATCH at %0t: is_output = %b, expected %b (adr %h)",
						$time, obs_word[DATA_W], exp_word[DATA_W], chk_address);
					$display("Test failed");
					$fatal(1);
				end
				assert (obs_word[DATA_W-1:0] == exp_word[DATA_W-1:0]) else begin
					$display("MISMATCH at %0t: o_data = %h, expected %h (adr %h)",
						$time, obs_word[DATA_W-1:0], exp_word[DATA_W-1:0], chk_address);
					$display("Test failed");
					$fatal(1);
				end
			end
		end
	end

	initial begin : watchdog
		cycle_count = 0;
		forever begin
			@(posedge clk);
			cycle_count++;
			if (cycle_count >= TIMEOUT_CYCLES) begin
				$display("timeout: test sequence still running after %0d cycles", cycle_count);
				$display("Test failed");
				$fatal(1);
			end
		end
	end

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		clk = 1'b0;
		n_reset = 1'b0;
		adr = '0;
		i_data = '0;
		n_sltsl = 1'b1;
		n_rd = 1'b1;
		n_wr = 1'b1;
		n_ioreq = 1'b1;
		void'($urandom(SEED));
		ref_bank0 = BANK0_RESET;
		ref_bank1 = BANK1_RESET;
		ref_scratch = '0;
		repeat (3) @(posedge clk);
		#1;
		n_reset = 1'b1;

		// reset state and bank register defaults
		check_idle();
		io_read(IO_BANK0_PORT);
		io_read(IO_BANK1_PORT);
		check_idle();

		// write then read back, both pages under the default banks
		mem_write(16'h4000, 8'h5A);
		mem_read(16'h4000);
		mem_write(16'h5FFF, 8'hA5);
		mem_read(16'h5FFF);
		mem_write(16'h6000, 8'h3C);
		mem_read(16'h6000);
		mem_write(16'h7FFF, 8'hC3);
		mem_read(16'h7FFF);

		// same window address under banks 3 and 2, then bank 2 seen through page 1
		io_write(IO_BANK0_PORT, 8'h03);
		mem_write(16'h4010, 8'h55);
		io_write(IO_BANK0_PORT, 8'h02);
		mem_write(16'h4010, 8'hAA);
		mem_read(16'h4010);
		io_write(IO_BANK0_PORT, 8'h03);
		mem_read(16'h4010);
		io_write(IO_BANK1_PORT, 8'h02);
		mem_read(16'h6010);
		io_write(IO_BANK0_PORT, BANK0_RESET);
		io_write(IO_BANK1_PORT, BANK1_RESET);
		mem_read(16'h4000);
		mem_read(16'h7FFF);

		// scratch byte, bank ports keep only BANK_W bits
		io_write(IO_SCRATCH_PORT, 8'h96);
		io_read(IO_SCRATCH_PORT);
		io_write(IO_BANK0_PORT, 8'hFE);
		io_read(IO_BANK0_PORT);
		io_write(IO_BANK1_PORT, 8'h7D);
		io_read(IO_BANK1_PORT);
		io_write(IO_BANK0_PORT, BANK0_RESET);
		io_write(IO_BANK1_PORT, BANK1_RESET);

		// unmapped accesses, then mapped ones must still complete
		mem_read(16'h8000);
		mem_read(16'h3FFF);
		mem_write(16'h2000, 8'h11);
		io_read(8'h10);
		io_write(8'h33, 8'h77);
		mem_read(16'h4000);
		io_read(IO_SCRATCH_PORT);

		fill_banks();
		random_accesses();
		repeat (2) @(posedge clk);

		if (observed_q.size() == 0) begin
			$display("Test passed");
			$finish;
		end else begin
			$display("unchecked reads left in the compare queue");
			$display("Test failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/msx_cart_pkg.sv
hw/msx_slot_bridge.sv
hw/cart_bus_decode.sv
hw/cart_banked_ram.sv
hw/cart_io_regs.sv
hw/msx_cartridge.sv
testbench/msx_cart_bus_assert.sv
testbench/tb_msx_cartridge.sv

// ==== Bender.yml ====
package:
  name: msx_cartridge

sources:
  - files:
      - hw/msx_cart_pkg.sv
      - hw/msx_slot_bridge.sv
      - hw/cart_bus_decode.sv
      - hw/cart_banked_ram.sv
      - hw/cart_io_regs.sv
      - hw/msx_cartridge.sv
  - target: simulation
    files:
      - testbench/msx_cart_bus_assert.sv
      - testbench/tb_msx_cartridge.sv
